// ==== dcache_data_stage.f ====
+incdir+include
hdl/dcache_geometry_pkg.sv
hdl/mem_access_pkg.sv
hdl/dcache_stage_if.sv
hdl/mem_access_decode.sv
hdl/way_hit_check.sv
hdl/store_align.sv
hdl/dcache_result.sv
hdl/dcache_data_stage.sv
test/dcache_data_stage_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the data stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
	--top-module dcache_data_stage_tb \
	-f dcache_data_stage.f \
	--Mdir obj_dir -o dcache_data_stage_sim
status=$?
if [ $status -ne 0 ]; then
	echo "verilator build failed with status $status"
	exit $status
fi

./obj_dir/dcache_data_stage_sim
status=$?
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit $status
fi
exit 0

// ==== include/dcache_ref_model.svh ====
// Reference predictions for the data stage testbench
// Alignment, hit and miss rules plus byte-level store mask and data
`ifndef DCACHE_REF_MODEL_SVH
`define DCACHE_REF_MODEL_SVH

function automatic logic ref_unaligned(mem_access_pkg::mem_access_t kind,
	dcache_geometry_pkg::paddr_t addr);
	case (kind)
		mem_access_pkg::MEM_S: return addr[0];
		mem_access_pkg::MEM_L, mem_access_pkg::MEM_SYNC: return addr[1] || addr[0];
		mem_access_pkg::MEM_BLOCK: return addr[5:0] != 6'd0;
		default: return 1'b0;
	endcase
endfunction

function automatic dcache_geometry_pkg::paddr_t ref_line_addr(dcache_geometry_pkg::paddr_t addr);
	return {addr[31:6], 6'd0};
endfunction

// Resident line counts only on the second synchronized load of a thread
function automatic logic ref_hit(logic resident, logic is_sync, logic pending);
	return resident && (!is_sync || pending);
endfunction

function automatic dcache_geometry_pkg::line_mask_t ref_store_mask(
	mem_access_pkg::mem_access_t kind, dcache_geometry_pkg::paddr_t addr,
	dcache_geometry_pkg::lane_mask_t lanes, logic is_load);
	dcache_geometry_pkg::line_mask_t mask;
	int off;
	mask = '0;
	off = int'(addr[5:0]);
	for (int i = 0; i < 64; i++)
	begin
		case (kind)
			mem_access_pkg::MEM_B: mask[i] = i == off;
			mem_access_pkg::MEM_S: mask[i] = i / 2 == off / 2;
			mem_access_pkg::MEM_BLOCK: mask[i] = lanes[15 - i / 4];
			default: mask[i] = i / 4 == off / 4;
		endcase
	end
	return is_load ? '0 : mask;
endfunction

function automatic dcache_geometry_pkg::line_data_t ref_store_data(
	mem_access_pkg::mem_access_t kind, input dcache_geometry_pkg::word_t value [16]);
	dcache_geometry_pkg::line_data_t data;
	for (int i = 0; i < 64; i++)
	begin
		case (kind)
			mem_access_pkg::MEM_B: data[i*8 +: 8] = value[0][7:0];
			mem_access_pkg::MEM_S: data[i*8 +: 8] = (i % 2 == 0) ? value[0][15:8] : value[0][7:0];
			mem_access_pkg::MEM_BLOCK: data[i*8 +: 8] = value[i / 4][31 - 8 * (i % 4) -: 8];
			default: data[i*8 +: 8] = value[0][31 - 8 * (i % 4) -: 8];
		endcase
	end
	return data;
endfunction

`endif

// ==== test/dcache_data_stage_tb.sv ====
`timescale 1ns/1ps
// Testbench for the L1 data cache data stage
// Keeps its own tag, line and sync-pending model, drives LFSR stimulus and
// compares same-cycle outputs and the registered results one cycle later

module dcache_data_stage_tb;
	import dcache_geometry_pkg::*;
	import mem_access_pkg::*;

	`include "dcache_ref_model.svh"

	localparam int NUM_WAYS = 4;
	localparam int NUM_THREADS = 4;
	localparam int WAY_BITS = 2;
	localparam int THREAD_BITS = 2;
	// Reset, fills, hit loads, miss loads, stores, faults, sync pairs, near misses, drain
	localparam int TEST_CYCLES = 3 + 8 + 8 + 8 + 41 + 8 + 8 + 4 + 2;
	localparam int TIMEOUT_CYCLES = 2 * TEST_CYCLES;

	typedef struct packed {
		logic valid;
		logic [THREAD_BITS-1:0] thread;
		logic rollback;
		logic suspend;
		logic fault;
		logic load;
		line_data_t line;
	} held_result_t;

	logic clk;
	logic reset;
	logic in_valid;
	logic in_is_load;
	mem_access_t in_kind;
	logic [THREAD_BITS-1:0] in_thread;
	paddr_t in_paddr;
	word_t in_store_value [LINE_WORDS];
	lane_mask_t in_lane_mask;
	logic [NUM_WAYS-1:0] way_valid;
	l1_tag_t way_tag [NUM_WAYS];
	logic fill_data_en;
	logic [WAY_BITS-1:0] fill_data_way;
	set_idx_t fill_data_set;
	line_data_t fill_data_line;
	logic fill_tag_en;
	set_idx_t fill_tag_set;
	l1_tag_t fill_tag_tag;
	logic cache_miss;
	paddr_t cache_miss_addr;
	logic [THREAD_BITS-1:0] cache_miss_thread;
	logic cache_miss_sync;
	logic store_en;
	line_mask_t store_mask;
	paddr_t store_addr;
	line_data_t store_data;
	logic [THREAD_BITS-1:0] store_thread;
	logic lru_update_en;
	logic [WAY_BITS-1:0] lru_update_way;
	logic out_valid;
	logic [THREAD_BITS-1:0] out_thread;
	line_data_t load_data;
	logic suspend_thread;
	logic rollback_en;
	logic access_fault;

	// Reference model state
	line_data_t model_line [NUM_WAYS][NUM_SETS];
	l1_tag_t model_tag [NUM_SETS][NUM_WAYS];
	logic model_valid [NUM_SETS][NUM_WAYS];
	logic [NUM_THREADS-1:0] sync_pending;
	l1_tag_t inst_tag [8];
	word_t store_vals [LINE_WORDS];
	logic [31:0] lfsr_state;
	logic checking;
	int cycle_count = 0;

	// Expected values for the access driven this cycle
	logic exp_access;
	logic exp_cache_miss;
	paddr_t exp_miss_addr;
	logic exp_miss_sync;
	logic [THREAD_BITS-1:0] exp_thread;
	logic exp_store_en;
	line_mask_t exp_store_mask;
	line_data_t exp_store_data;
	paddr_t exp_addr;
	logic exp_lru_en;
	logic [WAY_BITS-1:0] exp_lru_way;
	held_result_t pending_exp;
	held_result_t held;

	dcache_data_stage #(.NUM_WAYS(NUM_WAYS), .NUM_THREADS(NUM_THREADS)) uut (
		.clk(clk), .reset(reset),
		.in_valid(in_valid), .in_is_load(in_is_load), .in_kind(in_kind),
		.in_thread(in_thread), .in_paddr(in_paddr), .in_store_value(in_store_value),
		.in_lane_mask(in_lane_mask), .way_valid(way_valid), .way_tag(way_tag),
		.fill_data_en(fill_data_en), .fill_data_way(fill_data_way),
		.fill_data_set(fill_data_set), .fill_data_line(fill_data_line),
		.fill_tag_en(fill_tag_en), .fill_tag_set(fill_tag_set), .fill_tag_tag(fill_tag_tag),
		.cache_miss(cache_miss), .cache_miss_addr(cache_miss_addr),
		.cache_miss_thread(cache_miss_thread), .cache_miss_sync(cache_miss_sync),
		.store_en(store_en), .store_mask(store_mask), .store_addr(store_addr),
		.store_data(store_data), .store_thread(store_thread),
		.lru_update_en(lru_update_en), .lru_update_way(lru_update_way),
		.out_valid(out_valid), .out_thread(out_thread), .load_data(load_data),
		.suspend_thread(suspend_thread), .rollback_en(rollback_en),
		.access_fault(access_fault)
	);

	always #10 clk = !clk;

	task automatic report_failure(input string why);
		$display("%s", why);
		$display("Finished with errors");
		$fatal(1, "simulation stopped");
	endtask

	task automatic check_flag(input string name, input logic got, input logic expected);
		if (got !== expected)
			report_failure($sformatf("mismatch %s: got %h, expected %h", name, got, expected));
	endtask

	task automatic check_thread(input string name, input logic [THREAD_BITS-1:0] got,
		input logic [THREAD_BITS-1:0] expected);
		if (got !== expected)
			report_failure($sformatf("mismatch %s: got %h, expected %h", name, got, expected));
	endtask

	task automatic check_way(input string name, input logic [WAY_BITS-1:0] got,
		input logic [WAY_BITS-1:0] expected);
		if (got !== expected)
			report_failure($sformatf("mismatch %s: got %h, expected %h", name, got, expected));
	endtask

	task automatic check_addr(input string name, input paddr_t got, input paddr_t expected);
		if (got !== expected)
			report_failure($sformatf("mismatch %s: got %h, expected %h", name, got, expected));
	endtask

	task automatic check_mask(input string name, input line_mask_t got,
		input line_mask_t expected);
		if (got !== expected)
			report_failure($sformatf("mismatch %s: got %h, expected %h", name, got, expected));
	endtask

	task automatic check_line(input string name, input line_data_t got,
		input line_data_t expected);
		if (got !== expected)
			report_failure($sformatf("mismatch %s: got %h, expected %h", name, got, expected));
	endtask

	// Galois LFSR, x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
	endfunction

	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++)
		begin
			v[i] = lfsr_state[0];
			lfsr_state = lfsr_next(lfsr_state);
		end
		return v;
	endfunction

	function automatic mem_access_t pick_kind(input logic [31:0] r);
		case (r[1:0])
			2'd0: return MEM_B;
			2'd1: return MEM_S;
			2'd2: return MEM_L;
			default: return MEM_BLOCK;
		endcase
	endfunction

	function automatic line_offset_t aligned_offset(input mem_access_t kind);
		line_offset_t off;
		off = 6'(rand_bits(6));
		case (kind)
			MEM_B: return off;
			MEM_S: return off & 6'h3e;
			MEM_BLOCK: return 6'h00;
			default: return off & 6'h3c;
		endcase
	endfunction

	task automatic set_idle_exp();
		exp_access = 1'b0;
		exp_cache_miss = 1'b0;
		exp_store_en = 1'b0;
		exp_lru_en = 1'b0;
		pending_exp = '0;
	endtask

	task automatic idle_cycle();
		@(posedge clk);
		in_valid <= 1'b0;
		fill_data_en <= 1'b0;
		fill_tag_en <= 1'b0;
		set_idle_exp();
	endtask

	// Data and tag fill of one line, no access in the same cycle
	task automatic install_line(input int set_num, input int way, input l1_tag_t tag);
		line_data_t line;
		@(posedge clk);
		for (int i = 0; i < LINE_WORDS; i++)
			line[i*32 +: 32] = rand_bits(32);
		in_valid <= 1'b0;
		fill_data_en <= 1'b1;
		fill_data_way <= WAY_BITS'(way);
		fill_data_set <= SET_BITS'(set_num);
		fill_data_line <= line;
		fill_tag_en <= 1'b1;
		fill_tag_set <= SET_BITS'(set_num);
		fill_tag_tag <= tag;
		model_line[way][set_num] = line;
		model_tag[set_num][way] = tag;
		model_valid[set_num][way] = 1'b1;
		set_idle_exp();
	endtask

	task automatic issue(input logic is_load, input mem_access_t kind, input int thread,
		input paddr_t addr, input lane_mask_t lanes, input logic tag_fill);
		set_idx_t set_idx;
		l1_tag_t tag;
		logic resident;
		int res_way;
		logic hit;
		logic una;
		logic near;
		@(posedge clk);
		set_idx = addr[9:6];
		tag = addr[31:10];
		resident = 1'b0;
		res_way = 0;
		for (int w = 0; w < NUM_WAYS; w++)
		begin
			way_valid[w] <= model_valid[set_idx][w];
			way_tag[w] <= model_tag[set_idx][w];
			if (model_valid[set_idx][w] && model_tag[set_idx][w] == tag)
			begin
				resident = 1'b1;
				res_way = w;
			end
		end
		for (int i = 0; i < LINE_WORDS; i++)
		begin
			store_vals[i] = rand_bits(32);
			in_store_value[i] <= store_vals[i];
		end
		in_valid <= 1'b1;
		in_is_load <= is_load;
		in_kind <= kind;
		in_thread <= THREAD_BITS'(thread);
		in_paddr <= addr;
		in_lane_mask <= lanes;
		fill_data_en <= 1'b0;
		fill_tag_en <= tag_fill;
		fill_tag_set <= set_idx;
		fill_tag_tag <= tag;

		hit = ref_hit(resident, kind == MEM_SYNC, sync_pending[thread]);
		una = ref_unaligned(kind, addr);
		near = is_load && !hit && kind != MEM_SYNC && tag_fill;
		exp_access = 1'b1;
		exp_cache_miss = is_load && !una && !hit && !near;
		exp_miss_addr = ref_line_addr(addr);
		exp_miss_sync = kind == MEM_SYNC;
		exp_thread = THREAD_BITS'(thread);
		exp_store_mask = ref_store_mask(kind, addr, lanes, is_load);
		exp_store_data = ref_store_data(kind, store_vals);
		exp_store_en = !is_load && !una && exp_store_mask != '0;
		exp_addr = addr;
		exp_lru_en = !una && hit;
		exp_lru_way = WAY_BITS'(res_way);
		pending_exp = '{1'b1, THREAD_BITS'(thread), is_load && !hit,
			is_load && !hit && !near && !una, una, is_load && hit && !una,
			model_line[res_way][set_idx]};
		if (is_load && kind == MEM_SYNC)
			sync_pending[thread] = !sync_pending[thread];
	endtask

	// Same-cycle outputs against this cycle, registered outputs against the last one
	always @(negedge clk)
	begin
		if (checking)
		begin
			check_flag("out_valid", out_valid, held.valid);
			check_flag("rollback_en", rollback_en, held.rollback);
			check_flag("suspend_thread", suspend_thread, held.suspend);
			check_flag("access_fault", access_fault, held.fault);
			if (held.valid)
				check_thread("out_thread", out_thread, held.thread);
			if (held.load)
				check_line("load_data", load_data, held.line);
			check_flag("cache_miss", cache_miss, exp_cache_miss);
			if (exp_cache_miss)
			begin
				check_addr("cache_miss_addr", cache_miss_addr, exp_miss_addr);
				check_thread("cache_miss_thread", cache_miss_thread, exp_thread);
				check_flag("cache_miss_sync", cache_miss_sync, exp_miss_sync);
			end
			// Loads expect an empty mask
			if (exp_access)
				check_mask("store_mask", store_mask, exp_store_mask);
			check_flag("store_en", store_en, exp_store_en);
			if (exp_store_en)
			begin
				check_line("store_data", store_data, exp_store_data);
				check_addr("store_addr", store_addr, exp_addr);
				check_thread("store_thread", store_thread, exp_thread);
			end
			check_flag("lru_update_en", lru_update_en, exp_lru_en);
			if (exp_lru_en)
				check_way("lru_update_way", lru_update_way, exp_lru_way);
			held = pending_exp;
		end
	end

	always @(posedge clk)
	begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES)
			report_failure($sformatf("timeout after %0d cycles, stimulus did not complete",
				cycle_count));
	end

	initial
	begin
		mem_access_t kind;
		l1_tag_t tag;
		set_idx_t set_idx;
		lane_mask_t lanes;
		logic is_load;

		clk = 1'b0;
		checking = 1'b0;
		lfsr_state = 32'h977c;
		sync_pending = '0;
		held = '0;
		set_idle_exp();
		for (int s = 0; s < NUM_SETS; s++)
		begin
			for (int w = 0; w < NUM_WAYS; w++)
			begin
				model_valid[s][w] = 1'b0;
				model_tag[s][w] = '0;
			end
		end
		reset <= 1'b1;
		in_valid <= 1'b0;
		in_is_load <= 1'b0;
		in_kind <= MEM_B;
		in_thread <= '0;
		in_paddr <= '0;
		in_lane_mask <= '0;
		way_valid <= '0;
		for (int i = 0; i < LINE_WORDS; i++)
			in_store_value[i] <= '0;
		for (int w = 0; w < NUM_WAYS; w++)
			way_tag[w] <= '0;
		fill_data_en <= 1'b0;
		fill_data_way <= '0;
		fill_data_set <= '0;
		fill_data_line <= '0;
		fill_tag_en <= 1'b0;
		fill_tag_set <= '0;
		fill_tag_tag <= '0;

		repeat (3) @(posedge clk);
		reset <= 1'b0;
		checking = 1'b1;

		// Lines resident in sets 0 to 7, sets 8 to 15 stay empty
		for (int s = 0; s < 8; s++)
		begin
			inst_tag[s] = 22'(rand_bits(22));
			install_line(s, s % NUM_WAYS, inst_tag[s]);
		end

		// Hit loads
		for (int i = 0; i < 8; i++)
		begin
			kind = pick_kind(rand_bits(2));
			issue(1'b1, kind, int'(rand_bits(2)), {inst_tag[i], 4'(i), aligned_offset(kind)},
				'0, 1'b0);
		end

		// Miss loads
		for (int i = 0; i < 8; i++)
		begin
			kind = pick_kind(rand_bits(2));
			issue(1'b1, kind, int'(rand_bits(2)),
				{22'(rand_bits(22)), 4'(8 + i), aligned_offset(kind)}, '0, 1'b0);
		end

		// Stores, some to resident lines
		for (int i = 0; i < 40; i++)
		begin
			kind = pick_kind(rand_bits(2));
			set_idx = 4'(rand_bits(4));
			tag = 22'(rand_bits(22));
			if (set_idx < 8 && rand_bits(1) == 32'd1)
				tag = inst_tag[set_idx];
			lanes = 16'(rand_bits(16));
			issue(1'b0, kind, int'(rand_bits(2)), {tag, set_idx, aligned_offset(kind)},
				lanes, 1'b0);
		end
		issue(1'b0, MEM_BLOCK, 1, {inst_tag[2], 4'(2), 6'h00}, '0, 1'b0);

		// Unaligned stores to resident lines, unaligned loads to empty sets
		for (int i = 0; i < 8; i++)
		begin
			case (i % 3)
				0: kind = MEM_S;
				1: kind = MEM_L;
				default: kind = MEM_BLOCK;
			endcase
			is_load = i % 2 == 1;
			issue(is_load, kind, int'(rand_bits(2)),
				{inst_tag[i], is_load ? 4'(8 + i) : 4'(i), 6'(rand_bits(6)) | 6'h01},
				16'hffff, 1'b0);
		end

		// Synchronized load pairs, one per thread
		for (int t = 0; t < NUM_THREADS; t++)
		begin
			issue(1'b1, MEM_SYNC, t, {inst_tag[t], 4'(t), aligned_offset(MEM_L)}, '0, 1'b0);
			issue(1'b1, MEM_SYNC, t, {inst_tag[t], 4'(t), aligned_offset(MEM_L)}, '0, 1'b0);
		end

		// Misses racing a tag fill of the same line
		for (int i = 0; i < 4; i++)
			issue(1'b1, MEM_L, i, {22'(rand_bits(22)), 4'(12 + i), aligned_offset(MEM_L)},
				'0, 1'b1);

		idle_cycle();
		idle_cycle();
		@(posedge clk);
		$display("Finished with no errors");
		$finish;
	end

endmodule

// ==== hdl/dcache_data_stage.sv ====
`timescale 1ns/1ps
// L1 data cache data stage
// Hit check, line read, store alignment, miss and LRU update requests

module dcache_data_stage #(
	parameter int NUM_WAYS = 4,
	parameter int NUM_THREADS = 4,
	localparam int WAY_BITS = (NUM_WAYS > 1) ? $clog2(NUM_WAYS) : 1,
	localparam int THREAD_BITS = (NUM_THREADS > 1) ? $clog2(NUM_THREADS) : 1
) (
	input logic clk,
	input logic reset,

	// Access from the tag stage
	input logic in_valid,
	input logic in_is_load,
	input mem_access_pkg::mem_access_t in_kind,
	input logic [THREAD_BITS-1:0] in_thread,
	input dcache_geometry_pkg::paddr_t in_paddr,
	input dcache_geometry_pkg::word_t in_store_value [dcache_geometry_pkg::LINE_WORDS],
	input dcache_geometry_pkg::lane_mask_t in_lane_mask,
	input logic [NUM_WAYS-1:0] way_valid,
	input dcache_geometry_pkg::l1_tag_t way_tag [NUM_WAYS],

	// Fills from the L2 side
	input logic fill_data_en,
	input logic [WAY_BITS-1:0] fill_data_way,
	input dcache_geometry_pkg::set_idx_t fill_data_set,
	input dcache_geometry_pkg::line_data_t fill_data_line,
	input logic fill_tag_en,
	input dcache_geometry_pkg::set_idx_t fill_tag_set,
	input dcache_geometry_pkg::l1_tag_t fill_tag_tag,

	// Requests to L2, same cycle
	output logic cache_miss,
	output dcache_geometry_pkg::paddr_t cache_miss_addr,
	output logic [THREAD_BITS-1:0] cache_miss_thread,
	output logic cache_miss_sync,
	output logic store_en,
	output dcache_geometry_pkg::line_mask_t store_mask,
	output dcache_geometry_pkg::paddr_t store_addr,
	output dcache_geometry_pkg::line_data_t store_data,
	output logic [THREAD_BITS-1:0] store_thread,

	// Back to the tag stage
	output logic lru_update_en,
	output logic [WAY_BITS-1:0] lru_update_way,

	// To writeback, one cycle later
	output logic out_valid,
	output logic [THREAD_BITS-1:0] out_thread,
	output dcache_geometry_pkg::line_data_t load_data,
	output logic suspend_thread,
	output logic rollback_en,
	output logic access_fault
);
	import dcache_geometry_pkg::*;
	import mem_access_pkg::*;

	logic hit;
	logic [WAY_BITS-1:0] hit_way;
	logic near_miss;

	access_if #(.NUM_THREADS(NUM_THREADS)) acc();
	fill_if #(.NUM_WAYS(NUM_WAYS)) fill();

	assign fill.data_en = fill_data_en;
	assign fill.data_way = fill_data_way;
	assign fill.data_set = fill_data_set;
	assign fill.data_line = fill_data_line;
	assign fill.tag_en = fill_tag_en;
	assign fill.tag_set = fill_tag_set;
	assign fill.tag_tag = fill_tag_tag;

	mem_access_decode #(.NUM_THREADS(NUM_THREADS)) decode (
		.in_valid(in_valid),
		.in_is_load(in_is_load),
		.in_kind(in_kind),
		.in_thread(in_thread),
		.in_paddr(in_paddr),
		.acc(acc)
	);

	way_hit_check #(.NUM_WAYS(NUM_WAYS), .NUM_THREADS(NUM_THREADS)) hit_check (
		.clk(clk),
		.reset(reset),
		.acc(acc),
		.fill(fill),
		.way_valid(way_valid),
		.way_tag(way_tag),
		.hit(hit),
		.hit_way(hit_way),
		.near_miss(near_miss)
	);

	store_align align (
		.clk(clk),
		.acc(acc),
		.store_value(in_store_value),
		.lane_mask(in_lane_mask),
		.store_mask(store_mask),
		.store_data(store_data)
	);

	dcache_result #(.NUM_WAYS(NUM_WAYS), .NUM_THREADS(NUM_THREADS)) result (
		.clk(clk),
		.reset(reset),
		.acc(acc),
		.fill(fill),
		.hit(hit),
		.hit_way(hit_way),
		.near_miss(near_miss),
		.out_valid(out_valid),
		.out_thread(out_thread),
		.load_data(load_data),
		.suspend_thread(suspend_thread),
		.rollback_en(rollback_en),
		.access_fault(access_fault)
	);

	assign cache_miss = acc.valid && acc.is_load && !acc.unaligned && !hit && !near_miss;
	assign cache_miss_addr = {acc.paddr[PADDR_BITS-1:OFFSET_BITS], {OFFSET_BITS{1'b0}}};
	assign cache_miss_thread = acc.thread;
	assign cache_miss_sync = acc.kind == MEM_SYNC;

	// Empty block masks send nothing to L2
	assign store_en = acc.valid && !acc.is_load && !acc.unaligned && |store_mask;
	assign store_addr = acc.paddr;
	assign store_thread = acc.thread;

	assign lru_update_en = acc.valid && !acc.unaligned && hit;
	assign lru_update_way = hit_way;

endmodule

// ==== hdl/dcache_result.sv ====
`timescale 1ns/1ps
// Data array and completion flags
// Reads the hit line for a load, takes fills from L2, and registers
// the rollback, suspend and fault results one cycle after the access

module dcache_result #(
	parameter int NUM_WAYS = 4,
	parameter int NUM_THREADS = 4,
	localparam int WAY_BITS = (NUM_WAYS > 1) ? $clog2(NUM_WAYS) : 1,
	localparam int THREAD_BITS = (NUM_THREADS > 1) ? $clog2(NUM_THREADS) : 1
) (
	input logic clk,
	input logic reset,
	access_if.result acc,
	fill_if.data fill,
	input logic hit,
	input logic [WAY_BITS-1:0] hit_way,
	input logic near_miss,
	output logic out_valid,
	output logic [THREAD_BITS-1:0] out_thread,
	output dcache_geometry_pkg::line_data_t load_data,
	output logic suspend_thread,
	output logic rollback_en,
	output logic access_fault
);
	import dcache_geometry_pkg::*;

	localparam int ARRAY_DEPTH = NUM_WAYS * NUM_SETS;

	// Entry index is {way, set}
	line_data_t data_array [ARRAY_DEPTH];
	logic load_access;
	logic read_en;
	logic [WAY_BITS+SET_BITS-1:0] read_addr;
	logic [WAY_BITS+SET_BITS-1:0] write_addr;

	assign load_access = acc.valid && acc.is_load;
	assign read_en = load_access && hit && !acc.unaligned;
	assign read_addr = {hit_way, paddr_set(acc.paddr)};
	assign write_addr = {fill.data_way, fill.data_set};

	always_ff @(posedge clk)
	begin
		if (fill.data_en)
			data_array[write_addr] <= fill.data_line;
	end

	// Read port, new data wins when a fill hits the same entry
	always_ff @(posedge clk)
	begin
		out_thread <= acc.thread;
		if (read_en)
		begin
			if (fill.data_en && write_addr == read_addr)
				load_data <= fill.data_line;
			else
				load_data <= data_array[read_addr];
		end
	end

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			out_valid <= 1'b0;
			rollback_en <= 1'b0;
			suspend_thread <= 1'b0;
			access_fault <= 1'b0;
		end
		else
		begin
			out_valid <= acc.valid;
			rollback_en <= load_access && !hit;
			// Near miss retries without sleeping, since no wakeup would follow
			suspend_thread <= load_access && !hit && !near_miss && !acc.unaligned;
			access_fault <= acc.valid && acc.unaligned;
		end
	end

	// Returned line equals the array entry once a same-edge fill has landed
	read_matches_array_a: assert property (@(posedge clk) disable iff (reset)
		$past(read_en) |-> load_data == data_array[$past(read_addr)]);

endmodule

// ==== hdl/store_align.sv ====
`timescale 1ns/1ps
// Store alignment
// Builds the per-byte line mask and places store data in big-endian order

module store_align (
	input logic clk,
	access_if.align acc,
	input dcache_geometry_pkg::word_t store_value [dcache_geometry_pkg::LINE_WORDS],
	input dcache_geometry_pkg::lane_mask_t lane_mask,
	output dcache_geometry_pkg::line_mask_t store_mask,
	output dcache_geometry_pkg::line_data_t store_data
);
	import dcache_geometry_pkg::*;
	import mem_access_pkg::*;

	line_offset_t offset;
	word_t scalar;
	line_mask_t kind_mask;
	line_mask_t lane_byte_mask;
	line_data_t lane_data;

	assign offset = paddr_offset(acc.paddr);
	assign scalar = store_value[0];

	// Lane w covers bytes 4w..4w+3; lane 0 is the top bit of lane_mask
	always_comb
	begin
		for (int w = 0; w < LINE_WORDS; w++)
		begin
			lane_data[w*32 +: 32] = byte_swap(store_value[w]);
			lane_byte_mask[w*4 +: 4] = {4{lane_mask[LINE_WORDS-1-w]}};
		end
	end

	// Scalar data is replicated across the line so the mask alone picks the bytes
	always_comb
	begin
		case (acc.kind)
			MEM_B:
			begin
				kind_mask = line_mask_t'({BYTES_B{1'b1}}) << offset;
				store_data = {LINE_BYTES{scalar[7:0]}};
			end
			MEM_S:
			begin
				kind_mask = line_mask_t'({BYTES_S{1'b1}}) << {offset[OFFSET_BITS-1:1], 1'b0};
				store_data = {LINE_BYTES/2{scalar[7:0], scalar[15:8]}};
			end
			MEM_BLOCK:
			begin
				kind_mask = lane_byte_mask;
				store_data = lane_data;
			end
			default:
			begin
				// MEM_L and MEM_SYNC
				kind_mask = line_mask_t'({BYTES_L{1'b1}}) << {offset[OFFSET_BITS-1:2], 2'b00};
				store_data = {LINE_WORDS{byte_swap(scalar)}};
			end
		endcase
	end

	assign store_mask = acc.is_load ? '0 : kind_mask;

	// A scalar store always covers the byte its address points at
	store_covers_offset_a: assert property (@(posedge clk)
		acc.valid && !acc.is_load && acc.kind != MEM_BLOCK |-> store_mask[offset]);

endmodule

// ==== hdl/way_hit_check.sv ====
`timescale 1ns/1ps
// Hit detection for the data stage
// Compares way tags, encodes the hit way, tracks synchronized loads per thread
// and spots misses that race a tag fill of the same line

module way_hit_check #(
	parameter int NUM_WAYS = 4,
	parameter int NUM_THREADS = 4,
	localparam int WAY_BITS = (NUM_WAYS > 1) ? $clog2(NUM_WAYS) : 1
) (
	input logic clk,
	input logic reset,
	access_if.check acc,
	fill_if.tag fill,
	input logic [NUM_WAYS-1:0] way_valid,
	input dcache_geometry_pkg::l1_tag_t way_tag [NUM_WAYS],
	output logic hit,
	output logic [WAY_BITS-1:0] hit_way,
	output logic near_miss
);
	import dcache_geometry_pkg::*;
	import mem_access_pkg::*;

	localparam int THREAD_BITS = (NUM_THREADS > 1) ? $clog2(NUM_THREADS) : 1;

	logic [NUM_WAYS-1:0] way_hit_oh;
	logic [NUM_THREADS-1:0] sync_pending;
	logic is_sync;
	logic sync_load;
	l1_tag_t req_tag;

	assign req_tag = paddr_tag(acc.paddr);
	assign is_sync = acc.kind == MEM_SYNC;
	assign sync_load = acc.valid && acc.is_load && is_sync;

	always_comb
	begin
		for (int w = 0; w < NUM_WAYS; w++)
			way_hit_oh[w] = way_valid[w] && way_tag[w] == req_tag;
	end

	// One-hot to index
	always_comb
	begin
		hit_way = '0;
		for (int w = 0; w < NUM_WAYS; w++)
		begin
			if (way_hit_oh[w])
				hit_way = hit_way | WAY_BITS'(w);
		end
	end

	// First synchronized load goes to L2 to register the address, even if resident
	assign hit = |way_hit_oh && (!is_sync || sync_pending[acc.thread]);

	// The line is arriving right now, so the thread retries instead of sleeping
	assign near_miss = acc.valid && acc.is_load && !hit && !is_sync
		&& fill.tag_en
		&& fill.tag_set == paddr_set(acc.paddr)
		&& fill.tag_tag == req_tag;

	// Pending bit flips on each synchronized load: first request vs. the retry
	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
			sync_pending <= '0;
		else
		begin
			for (int t = 0; t < NUM_THREADS; t++)
			begin
				if (sync_load && acc.thread == THREAD_BITS'(t))
					sync_pending[t] <= !sync_pending[t];
			end
		end
	end

	// Tag stage must never hold a line in two ways of one set
	hit_onehot_a: assert property (@(posedge clk) disable iff (reset)
		acc.valid |-> $onehot0(way_hit_oh));

endmodule

// ==== hdl/mem_access_decode.sv ====
`timescale 1ns/1ps
// Access decode
// Forwards the incoming access onto access_if and flags unaligned addresses

module mem_access_decode #(
	parameter int NUM_THREADS = 4,
	localparam int THREAD_BITS = (NUM_THREADS > 1) ? $clog2(NUM_THREADS) : 1
) (
	input logic in_valid,
	input logic in_is_load,
	input mem_access_pkg::mem_access_t in_kind,
	input logic [THREAD_BITS-1:0] in_thread,
	input dcache_geometry_pkg::paddr_t in_paddr,
	access_if.decode acc
);
	import dcache_geometry_pkg::*;
	import mem_access_pkg::*;

	line_offset_t offset;

	assign offset = paddr_offset(in_paddr);

	assign acc.valid = in_valid;
	assign acc.is_load = in_is_load;
	assign acc.kind = in_kind;
	assign acc.thread = in_thread;
	assign acc.paddr = in_paddr;

	// Each kind must sit on its natural boundary
	always_comb
	begin
		case (in_kind)
			MEM_B:
				acc.unaligned = |(offset & ALIGN_B);
			MEM_S:
				acc.unaligned = |(offset & ALIGN_S);
			MEM_L, MEM_SYNC:
				acc.unaligned = |(offset & ALIGN_L);
			MEM_BLOCK:
				acc.unaligned = |(offset & ALIGN_BLOCK);
			default:
				acc.unaligned = 1'b0;
		endcase
	end

endmodule

// ==== hdl/dcache_stage_if.sv ====
`timescale 1ns/1ps
// Interfaces of the data stage
// access_if carries the decoded access, fill_if the data and tag updates from L2

interface access_if #(
	parameter int NUM_THREADS = 4
);
	import dcache_geometry_pkg::*;
	import mem_access_pkg::*;

	localparam int THREAD_BITS = (NUM_THREADS > 1) ? $clog2(NUM_THREADS) : 1;

	logic valid;
	logic is_load;
	mem_access_t kind;
	logic [THREAD_BITS-1:0] thread;
	paddr_t paddr;
	logic unaligned;

	modport decode(output valid, is_load, kind, thread, paddr, unaligned);
	modport check(input valid, is_load, kind, thread, paddr);
	modport align(input valid, is_load, kind, paddr);
	modport result(input valid, is_load, thread, paddr, unaligned);
endinterface

interface fill_if #(
	parameter int NUM_WAYS = 4
);
	import dcache_geometry_pkg::*;

	localparam int WAY_BITS = (NUM_WAYS > 1) ? $clog2(NUM_WAYS) : 1;

	// Line data written into one way of a set
	logic data_en;
	logic [WAY_BITS-1:0] data_way;
	set_idx_t data_set;
	line_data_t data_line;

	// Tag being installed by the tag stage this cycle
	logic tag_en;
	set_idx_t tag_set;
	l1_tag_t tag_tag;

	modport data(input data_en, data_way, data_set, data_line);
	modport tag(input tag_en, tag_set, tag_tag);
endinterface

// ==== hdl/mem_access_pkg.sv ====
// Memory access kinds of the data stage
// Kind encoding and the offset bits each kind needs clear to be aligned
package mem_access_pkg;

	typedef enum logic [2:0] {
		MEM_B,
		MEM_S,
		MEM_L,
		MEM_SYNC,
		MEM_BLOCK
	} mem_access_t;

	// Offset bits that must be zero, per kind
	localparam logic [dcache_geometry_pkg::OFFSET_BITS-1:0] ALIGN_B = 6'h00;
	localparam logic [dcache_geometry_pkg::OFFSET_BITS-1:0] ALIGN_S = 6'h01;
	localparam logic [dcache_geometry_pkg::OFFSET_BITS-1:0] ALIGN_L = 6'h03;
	localparam logic [dcache_geometry_pkg::OFFSET_BITS-1:0] ALIGN_BLOCK = 6'h3f;

	// Number of bytes a scalar kind touches
	localparam int BYTES_B = 1;
	localparam int BYTES_S = 2;
	localparam int BYTES_L = 4;

endpackage

// ==== hdl/dcache_geometry_pkg.sv ====
// L1 data cache geometry
// Address split into tag, set and line offset, plus the line and word types
package dcache_geometry_pkg;

	localparam int LINE_BYTES = 64;
	localparam int LINE_WORDS = 16;
	localparam int OFFSET_BITS = 6;
	localparam int SET_BITS = 4;
	localparam int TAG_BITS = 22;
	localparam int NUM_SETS = 1 << SET_BITS;
	localparam int PADDR_BITS = TAG_BITS + SET_BITS + OFFSET_BITS;

	typedef logic [31:0] word_t;
	typedef logic [PADDR_BITS-1:0] paddr_t;
	typedef logic [OFFSET_BITS-1:0] line_offset_t;
	typedef logic [SET_BITS-1:0] set_idx_t;
	typedef logic [TAG_BITS-1:0] l1_tag_t;
	typedef logic [LINE_BYTES*8-1:0] line_data_t;
	typedef logic [LINE_BYTES-1:0] line_mask_t;
	typedef logic [LINE_WORDS-1:0] lane_mask_t;

	// Address fields, tag on top and offset at the bottom
	function automatic line_offset_t paddr_offset(paddr_t addr);
		return addr[OFFSET_BITS-1:0];
	endfunction

	function automatic set_idx_t paddr_set(paddr_t addr);
		return addr[OFFSET_BITS +: SET_BITS];
	endfunction

	function automatic l1_tag_t paddr_tag(paddr_t addr);
		return addr[PADDR_BITS-1 -: TAG_BITS];
	endfunction

	// Big-endian word placement: the most significant byte lands at the lowest address
	function automatic word_t byte_swap(word_t value);
		return {value[7:0], value[15:8], value[23:16], value[31:24]};
	endfunction

endpackage
